//--- Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FLIST     ?= verilog.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) --binary --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/rv_core_tb.sv
`timescale 1ns/1ns
`include "rv_config.svh"

module rv_core_tb;
   localparam int AW = $clog2(`RV_IMEM_WORDS);
   localparam int PROG_LEN = 32;
   localparam int LOAD_CYCLES = PROG_LEN + 6;
   localparam int TIMEOUT_CYCLES = 4 * (LOAD_CYCLES + 8 * PROG_LEN + 50);

   logic          clk;
   logic          reset;
   logic          run_i;
   logic          imem_we_i;
   logic [AW-1:0] imem_addr_i;
   logic [31:0]   imem_data_i;
   logic          retire_valid_o;
   logic [31:0]   retire_pc_o;
   logic          retire_we_o;
   logic [4:0]    retire_rd_o;
   logic [31:0]   retire_data_o;
   int            errors;
   int            pending;

   logic [31:0]      lfsr = 32'h32b6;
   int               cycle_count = 0;
   int               tb_errors = 0;
   int               pass_count = 0;
   int               fail_count = 0;
   rv_pkg::rv_op_e   p_op  [256];
   logic [4:0]       p_rd  [256];
   logic [4:0]       p_rs1 [256];
   logic [4:0]       p_rs2 [256];
   logic [31:0]      p_imm [256];

   rv_core rv_core_i (
      .clk            (clk),
      .reset          (reset),
      .run_i          (run_i),
      .imem_we_i      (imem_we_i),
      .imem_addr_i    (imem_addr_i),
      .imem_data_i    (imem_data_i),
      .retire_valid_o (retire_valid_o),
      .retire_pc_o    (retire_pc_o),
      .retire_we_o    (retire_we_o),
      .retire_rd_o    (retire_rd_o),
      .retire_data_o  (retire_data_o)
   );

   rv_retire_checker rv_retire_checker_i (
      .clk            (clk),
      .reset          (reset),
      .retire_valid_i (retire_valid_o),
      .retire_pc_i    (retire_pc_o),
      .retire_we_i    (retire_we_o),
      .retire_rd_i    (retire_rd_o),
      .retire_data_i  (retire_data_o),
      .errors_o       (errors),
      .pending_o      (pending)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Simulation failed");
         $finish;
      end
   end

   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic rv_pkg::rv_op_e pick_alu_op();
      case (rand_bits(4) % 11)
         0:       return rv_pkg::OP_ADD;
         1:       return rv_pkg::OP_SUB;
         2:       return rv_pkg::OP_AND;
         3:       return rv_pkg::OP_OR;
         4:       return rv_pkg::OP_XOR;
         5:       return rv_pkg::OP_SLT;
         6:       return rv_pkg::OP_ADDI;
         7:       return rv_pkg::OP_ANDI;
         8:       return rv_pkg::OP_ORI;
         9:       return rv_pkg::OP_XORI;
         default: return rv_pkg::OP_LUI;
      endcase
   endfunction

   function automatic logic [4:0] any_reg();
      return 5'(rand_bits(3));
   endfunction

   function automatic logic [4:0] nonzero_reg();
      return 5'(1 + rand_bits(3) % 7);
   endfunction

   // RV32I instruction encoding
   function automatic logic [31:0] encode(input int a);
      logic [31:0] m;
      logic [4:0]  rd;
      logic [4:0]  s1;
      logic [4:0]  s2;
      m  = p_imm[a];
      rd = p_rd[a];
      s1 = p_rs1[a];
      s2 = p_rs2[a];
      case (p_op[a])
         rv_pkg::OP_ADD:  return {7'h00, s2, s1, 3'b000, rd, rv_pkg::OPC_OP};
         rv_pkg::OP_SUB:  return {7'h20, s2, s1, 3'b000, rd, rv_pkg::OPC_OP};
         rv_pkg::OP_AND:  return {7'h00, s2, s1, 3'b111, rd, rv_pkg::OPC_OP};
         rv_pkg::OP_OR:   return {7'h00, s2, s1, 3'b110, rd, rv_pkg::OPC_OP};
         rv_pkg::OP_XOR:  return {7'h00, s2, s1, 3'b100, rd, rv_pkg::OPC_OP};
         rv_pkg::OP_SLT:  return {7'h00, s2, s1, 3'b010, rd, rv_pkg::OPC_OP};
         rv_pkg::OP_ADDI: return {m[11:0], s1, 3'b000, rd, rv_pkg::OPC_OP_IMM};
         rv_pkg::OP_ANDI: return {m[11:0], s1, 3'b111, rd, rv_pkg::OPC_OP_IMM};
         rv_pkg::OP_ORI:  return {m[11:0], s1, 3'b110, rd, rv_pkg::OPC_OP_IMM};
         rv_pkg::OP_XORI: return {m[11:0], s1, 3'b100, rd, rv_pkg::OPC_OP_IMM};
         rv_pkg::OP_LUI:  return {m[31:12], rd, rv_pkg::OPC_LUI};
         rv_pkg::OP_LW:   return {m[11:0], s1, 3'b010, rd, rv_pkg::OPC_LOAD};
         rv_pkg::OP_SW:   return {m[11:5], s2, s1, 3'b010, m[4:0], rv_pkg::OPC_STORE};
         rv_pkg::OP_BEQ:
            return {m[12], m[10:5], s2, s1, 3'b000, m[4:1], m[11], rv_pkg::OPC_BRANCH};
         rv_pkg::OP_BNE:
            return {m[12], m[10:5], s2, s1, 3'b001, m[4:1], m[11], rv_pkg::OPC_BRANCH};
         rv_pkg::OP_JAL:  return {m[20], m[10:1], m[11], m[19:12], rd, rv_pkg::OPC_JAL};
         default:         return 32'h0;
      endcase
   endfunction

   // kind 1 alu chains, 2 loads and stores, 3 branches, 4 x0 writes
   task automatic build_program(input int kind);
      logic [4:0] prev [3];
      logic [31:0] r;
      logic [11:0] imm12;
      int         off;
      bit         use_load;
      prev     = '{5'd1, 5'd2, 5'd3};
      use_load = 1'b0;
      for (int i = 0; i < PROG_LEN; i++) begin
         p_op[i]  = pick_alu_op();
         p_rd[i]  = nonzero_reg();
         p_rs1[i] = any_reg();
         p_rs2[i] = any_reg();
         imm12    = 12'(rand_bits(12));
         p_imm[i] = {{20{imm12[11]}}, imm12};
         if (p_op[i] == rv_pkg::OP_LUI) begin
            p_imm[i] = {20'(rand_bits(20)), 12'h0};
         end
         r = rand_bits(3);
         if (kind == 1) begin
            p_rs1[i] = prev[0];
            p_rs2[i] = (rand_bits(1) == 1) ? prev[1] : prev[2];
         end else if (kind == 2) begin
            if (use_load) begin
               // consume the load result right away
               p_op[i]  = rv_pkg::OP_ADD;
               p_rs1[i] = prev[0];
            end else if (r < 4) begin
               p_op[i]  = rv_pkg::OP_SW;
               p_rs1[i] = 5'd0;
               p_imm[i] = 32'(4 * (rand_bits(6) % 16));
            end else if (r < 7) begin
               p_op[i]  = rv_pkg::OP_LW;
               p_rs1[i] = 5'd0;
               p_imm[i] = 32'(4 * (rand_bits(6) % 16));
            end
            use_load = (p_op[i] == rv_pkg::OP_LW);
         end else if (kind == 3) begin
            if (r >= 4 && r < 7) begin
               p_op[i] = (r == 4) ? rv_pkg::OP_BEQ :
                         (r == 5) ? rv_pkg::OP_BNE : rv_pkg::OP_JAL;
               off = 4 * (1 + int'(rand_bits(2) % 3));
               if (4 * i + off > 4 * PROG_LEN) begin
                  off = 4 * (PROG_LEN - i);
               end
               p_imm[i] = 32'(off);
               if (p_op[i] == rv_pkg::OP_JAL) begin
                  p_rd[i] = any_reg();
               end
            end
         end else begin
            if (rand_bits(1) == 1) begin
               p_rd[i] = 5'd0;
            end
            if (rand_bits(1) == 1) begin
               p_rs1[i] = 5'd0;
            end
         end
         prev = '{p_rd[i], prev[0], prev[1]};
      end
      // halt by jumping to itself
      p_op[PROG_LEN]  = rv_pkg::OP_JAL;
      p_rd[PROG_LEN]  = 5'd0;
      p_rs1[PROG_LEN] = 5'd0;
      p_rs2[PROG_LEN] = 5'd0;
      p_imm[PROG_LEN] = 32'h0;
   endtask

   // architectural model that pushes one record per retired instruction
   task automatic run_model();
      logic [31:0] regs [32];
      logic [31:0] dmem [64];
      logic [31:0] pc;
      logic [31:0] next_pc;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] m;
      logic [31:0] res;
      logic        we;
      logic [4:0]  rd;
      int          idx;
      int          halts;
      regs  = '{default: '0};
      dmem  = '{default: '0};
      pc    = '0;
      halts = 0;
      while (halts < 2) begin
         idx     = int'(pc[31:2]);
         a       = regs[p_rs1[idx]];
         b       = regs[p_rs2[idx]];
         m       = p_imm[idx];
         we      = 1'b1;
         rd      = p_rd[idx];
         next_pc = pc + 32'd4;
         case (p_op[idx])
            rv_pkg::OP_ADD:  res = a + b;
            rv_pkg::OP_SUB:  res = a - b;
            rv_pkg::OP_AND:  res = a & b;
            rv_pkg::OP_OR:   res = a | b;
            rv_pkg::OP_XOR:  res = a ^ b;
            rv_pkg::OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            rv_pkg::OP_ADDI: res = a + m;
            rv_pkg::OP_ANDI: res = a & m;
            rv_pkg::OP_ORI:  res = a | m;
            rv_pkg::OP_XORI: res = a ^ m;
            rv_pkg::OP_LUI:  res = m;
            rv_pkg::OP_LW: begin
               res = a + m;
               res = dmem[res[7:2]];
            end
            rv_pkg::OP_SW: begin
               res           = a + m;
               dmem[res[7:2]] = b;
               we            = 1'b0;
               rd            = 5'd0;
            end
            rv_pkg::OP_JAL: begin
               res     = pc + 32'd4;
               next_pc = pc + m;
               if (idx == PROG_LEN) begin
                  halts++;
               end
            end
            default: begin
               res = '0;
               we  = 1'b0;
               rd  = 5'd0;
               if ((p_op[idx] == rv_pkg::OP_BEQ) == (a == b)) begin
                  next_pc = pc + m;
               end
            end
         endcase
         // x0 keeps zero and its retire data is not stored
         if (we && rd != 5'd0) begin
            regs[rd] = res;
         end
         rv_retire_checker_i.push_expected(pc, we, rd, res);
         pc = next_pc;
      end
   endtask

   task automatic run_test(input int kind, input string name);
      int errs_before;
      errs_before = errors + tb_errors;
      @(posedge clk);
      reset <= 1'b1;
      run_i <= 1'b0;
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      build_program(kind);
      // zero words after the halt decode as bubbles
      for (int a = 0; a < PROG_LEN + 4; a++) begin
         @(posedge clk);
         imem_we_i   <= 1'b1;
         imem_addr_i <= AW'(a);
         imem_data_i <= (a <= PROG_LEN) ? encode(a) : 32'h0;
      end
      @(posedge clk);
      imem_we_i <= 1'b0;
      // idle with run_i low so any retire here is stale
      repeat (2) @(posedge clk);
      run_model();
      @(posedge clk);
      run_i <= 1'b1;
      do begin
         @(posedge clk);
      end while (!(retire_valid_o === 1'b1 && retire_pc_o == 32'(4 * PROG_LEN)));
      run_i <= 1'b0;
      repeat (12) @(posedge clk);
      if (pending != 0) begin
         $display("test %0d: %0d expected retirements never happened", kind, pending);
         tb_errors++;
      end
      if (errors + tb_errors == errs_before) begin
         pass_count++;
         $display("test %0d %s: ok", kind, name);
      end else begin
         fail_count++;
         $display("test %0d %s: failed", kind, name);
      end
   endtask

   initial begin
      reset       = 1'b1;
      run_i       = 1'b0;
      imem_we_i   = 1'b0;
      imem_addr_i = '0;
      imem_data_i = '0;
      run_test(1, "alu forwarding");
      run_test(2, "load and store");
      run_test(3, "branches and jumps");
      run_test(4, "x0 writes");
      $display("tests passed %0d failed %0d", pass_count, fail_count);
      if (fail_count == 0 && errors == 0 && tb_errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- bench/rv_retire_checker.sv
`timescale 1ns/1ns
`include "rv_config.svh"

// compares every retirement with the next expected record
module rv_retire_checker (
   input  logic                clk,
   input  logic                reset,
   input  logic                retire_valid_i,
   input  logic [`RV_XLEN-1:0] retire_pc_i,
   input  logic                retire_we_i,
   input  logic [4:0]          retire_rd_i,
   input  logic [`RV_XLEN-1:0] retire_data_i,
   output int                  errors_o,
   output int                  pending_o
);
   // record layout is pc, we, rd, data
   logic [69:0] exp_q [$];

   initial begin
      errors_o  = 0;
      pending_o = 0;
   end

   task automatic push_expected(input logic [31:0] pc, input logic we,
                                input logic [4:0] rd, input logic [31:0] data);
      exp_q.push_back({pc, we, rd, data});
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                  input logic [31:0] act_val);
      $display("FAILED at %0t ns: %s expected %h got %h", $time, name, exp_val, act_val);
      errors_o = errors_o + 1;
   endtask

   always @(posedge clk) begin
      logic [69:0] rec;
      if (!reset && retire_valid_i === 1'b1) begin
         if (exp_q.size() == 0) begin
            $display("unexpected retirement at %0t ns with pc %h", $time, retire_pc_i);
            errors_o = errors_o + 1;
         end else begin
            rec = exp_q.pop_front();
            if (retire_pc_i !== rec[69:38]) begin
               report_mismatch("retire_pc_o", rec[69:38], retire_pc_i);
            end
            if (retire_we_i !== rec[37]) begin
               report_mismatch("retire_we_o", 32'(rec[37]), 32'(retire_we_i));
            end
            if (retire_rd_i !== rec[36:32]) begin
               report_mismatch("retire_rd_o", 32'(rec[36:32]), 32'(retire_rd_i));
            end
            if (retire_data_i !== rec[31:0]) begin
               report_mismatch("retire_data_o", rec[31:0], retire_data_i);
            end
         end
      end
      pending_o <= exp_q.size();
   end

endmodule

//--- source/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data path width
`define RV_XLEN 32

// architectural registers
`define RV_NREGS 32

// memory depths in words
`define RV_IMEM_WORDS 256
`define RV_DMEM_WORDS 256

`endif

//--- source/rv_core.sv
`timescale 1ns/1ns
`include "rv_config.svh"

module rv_core (
   input  logic                               clk,
   input  logic                               reset,
   input  logic                               run_i,
   input  logic                               imem_we_i,
   input  logic [$clog2(`RV_IMEM_WORDS)-1:0]  imem_addr_i,
   input  logic [31:0]                        imem_data_i,
   output logic                               retire_valid_o,
   output logic [`RV_XLEN-1:0]                retire_pc_o,
   output logic                               retire_we_o,
   output logic [4:0]                         retire_rd_o,
   output logic [`RV_XLEN-1:0]                retire_data_o
);
   logic                f_valid;
   logic [`RV_XLEN-1:0] f_pc;
   logic [31:0]         f_instr;

   rv_pkg::rv_ctrl_t    d_ctrl;
   logic [`RV_XLEN-1:0] d_pc;
   logic [`RV_XLEN-1:0] d_op1;
   logic [`RV_XLEN-1:0] d_op2;
   logic [`RV_XLEN-1:0] d_imm;

   rv_pkg::rv_ctrl_t    e_ctrl;
   logic [`RV_XLEN-1:0] e_result;
   logic [`RV_XLEN-1:0] e_store;
   logic [`RV_XLEN-1:0] e_pc;
   logic                redirect;
   logic [`RV_XLEN-1:0] target;

   logic [`RV_XLEN-1:0] m_pc;

   rv_wb_if mem_bus ();
   rv_wb_if wb_bus ();

   rv_fetch rv_fetch_i (
      .clk         (clk),
      .reset       (reset),
      .run_i       (run_i),
      .imem_we_i   (imem_we_i),
      .imem_addr_i (imem_addr_i),
      .imem_data_i (imem_data_i),
      .redirect_i  (redirect),
      .target_i    (target),
      .valid_o     (f_valid),
      .pc_o        (f_pc),
      .instr_o     (f_instr)
   );

   // a taken branch also flushes decode and execute
   rv_decode rv_decode_i (
      .clk     (clk),
      .reset   (reset),
      .flush_i (redirect),
      .valid_i (f_valid),
      .pc_i    (f_pc),
      .instr_i (f_instr),
      .wb      (wb_bus),
      .ctrl_o  (d_ctrl),
      .pc_o    (d_pc),
      .op1_o   (d_op1),
      .op2_o   (d_op2),
      .imm_o   (d_imm)
   );

   rv_execute rv_execute_i (
      .clk        (clk),
      .reset      (reset),
      .flush_i    (redirect),
      .ctrl_i     (d_ctrl),
      .pc_i       (d_pc),
      .op1_i      (d_op1),
      .op2_i      (d_op2),
      .imm_i      (d_imm),
      .mem_fwd    (mem_bus),
      .wb_fwd     (wb_bus),
      .redirect_o (redirect),
      .target_o   (target),
      .ctrl_o     (e_ctrl),
      .result_o   (e_result),
      .store_o    (e_store),
      .pc_o       (e_pc)
   );

   rv_memory rv_memory_i (
      .clk      (clk),
      .reset    (reset),
      .ctrl_i   (e_ctrl),
      .pc_i     (e_pc),
      .result_i (e_result),
      .store_i  (e_store),
      .mem_bus  (mem_bus),
      .wb_bus   (wb_bus),
      .pc_o     (m_pc)
   );

   // retire straight from the write-back stage
   assign retire_valid_o = wb_bus.valid;
   assign retire_pc_o    = m_pc;
   assign retire_we_o    = wb_bus.we;
   assign retire_rd_o    = wb_bus.rd;
   assign retire_data_o  = wb_bus.data;

endmodule

//--- source/rv_decode.sv
`timescale 1ns/1ns
`include "rv_config.svh"

module rv_decode (
   input  logic                clk,
   input  logic                reset,
   input  logic                flush_i,
   input  logic                valid_i,
   input  logic [`RV_XLEN-1:0] pc_i,
   input  logic [31:0]         instr_i,
   rv_wb_if.wr                 wb,
   output rv_pkg::rv_ctrl_t    ctrl_o,
   output logic [`RV_XLEN-1:0] pc_o,
   output logic [`RV_XLEN-1:0] op1_o,
   output logic [`RV_XLEN-1:0] op2_o,
   output logic [`RV_XLEN-1:0] imm_o
);
   rv_pkg::rv_instr_u   instr;
   rv_pkg::rv_ctrl_t    ctrl;
   logic [`RV_XLEN-1:0] imm;
   logic [`RV_XLEN-1:0] rd1;
   logic [`RV_XLEN-1:0] rd2;

   assign instr = instr_i;

   rv_reg_file rv_reg_file_i (
      .clk   (clk),
      .reset (reset),
      .rs1_i (ctrl.rs1),
      .rs2_i (ctrl.rs2),
      .rd1_o (rd1),
      .rd2_o (rd2),
      .wb    (wb)
   );

   always_comb begin
      ctrl     = '0;
      imm      = '0;
      ctrl.rd  = instr.r.rd;
      ctrl.rs1 = instr.r.rs1;
      ctrl.rs2 = instr.r.rs2;
      case (instr.r.opcode)
         rv_pkg::OPC_OP: begin
            ctrl.reg_write = 1'b1;
            case ({instr.r.funct7, instr.r.funct3})
               {7'h00, 3'b000}: ctrl.op = rv_pkg::OP_ADD;
               {7'h20, 3'b000}: ctrl.op = rv_pkg::OP_SUB;
               {7'h00, 3'b111}: ctrl.op = rv_pkg::OP_AND;
               {7'h00, 3'b110}: ctrl.op = rv_pkg::OP_OR;
               {7'h00, 3'b100}: ctrl.op = rv_pkg::OP_XOR;
               {7'h00, 3'b010}: ctrl.op = rv_pkg::OP_SLT;
               default:         ctrl.op = rv_pkg::OP_NOP;
            endcase
         end
         rv_pkg::OPC_OP_IMM: begin
            ctrl.reg_write = 1'b1;
            ctrl.rs2       = 5'd0;
            imm            = {{20{instr.i.imm[11]}}, instr.i.imm};
            case (instr.i.funct3)
               3'b000:  ctrl.op = rv_pkg::OP_ADDI;
               3'b111:  ctrl.op = rv_pkg::OP_ANDI;
               3'b110:  ctrl.op = rv_pkg::OP_ORI;
               3'b100:  ctrl.op = rv_pkg::OP_XORI;
               default: ctrl.op = rv_pkg::OP_NOP;
            endcase
         end
         rv_pkg::OPC_LUI: begin
            ctrl.op        = rv_pkg::OP_LUI;
            ctrl.reg_write = 1'b1;
            ctrl.rs1       = 5'd0;
            ctrl.rs2       = 5'd0;
            // upper 20 bits of the word
            imm            = {instr.i.imm, instr.i.rs1, instr.i.funct3, 12'b0};
         end
         rv_pkg::OPC_LOAD: begin
            ctrl.op        = (instr.i.funct3 == 3'b010) ? rv_pkg::OP_LW : rv_pkg::OP_NOP;
            ctrl.reg_write = 1'b1;
            ctrl.mem_read  = 1'b1;
            ctrl.rs2       = 5'd0;
            imm            = {{20{instr.i.imm[11]}}, instr.i.imm};
         end
         rv_pkg::OPC_STORE: begin
            ctrl.op        = (instr.s.funct3 == 3'b010) ? rv_pkg::OP_SW : rv_pkg::OP_NOP;
            ctrl.mem_write = 1'b1;
            ctrl.rd        = 5'd0;
            imm            = {{20{instr.s.imm11_5[6]}}, instr.s.imm11_5, instr.s.imm4_0};
         end
         rv_pkg::OPC_BRANCH: begin
            case (instr.r.funct3)
               3'b000:  ctrl.op = rv_pkg::OP_BEQ;
               3'b001:  ctrl.op = rv_pkg::OP_BNE;
               default: ctrl.op = rv_pkg::OP_NOP;
            endcase
            ctrl.rd = 5'd0;
            imm     = {{20{instr.bj.sign}}, instr.bj.b_imm11, instr.bj.imm10_5,
                       instr.bj.b_imm4_1, 1'b0};
         end
         rv_pkg::OPC_JAL: begin
            ctrl.op        = rv_pkg::OP_JAL;
            ctrl.reg_write = 1'b1;
            ctrl.rs1       = 5'd0;
            ctrl.rs2       = 5'd0;
            imm            = {{12{instr.bj.sign}}, instr.bj.j_imm19_12, instr.bj.j_imm11,
                              instr.bj.imm10_5, instr.bj.j_imm4_1, 1'b0};
         end
         default: ;
      endcase
      // unsupported encodings leave as bubbles
      ctrl.valid = valid_i && (ctrl.op != rv_pkg::OP_NOP);
      if (!ctrl.valid) begin
         ctrl.reg_write = 1'b0;
         ctrl.mem_read  = 1'b0;
         ctrl.mem_write = 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (reset || flush_i) begin
         ctrl_o <= '0;
      end else begin
         ctrl_o <= ctrl;
      end
   end

   always_ff @(posedge clk) begin
      pc_o  <= pc_i;
      op1_o <= rd1;
      op2_o <= rd2;
      imm_o <= imm;
   end

endmodule

//--- source/rv_execute.sv
`timescale 1ns/1ns
`include "rv_config.svh"

module rv_execute (
   input  logic                clk,
   input  logic                reset,
   input  logic                flush_i,
   input  rv_pkg::rv_ctrl_t    ctrl_i,
   input  logic [`RV_XLEN-1:0] pc_i,
   input  logic [`RV_XLEN-1:0] op1_i,
   input  logic [`RV_XLEN-1:0] op2_i,
   input  logic [`RV_XLEN-1:0] imm_i,
   rv_wb_if.fwd                mem_fwd,
   rv_wb_if.fwd                wb_fwd,
   output logic                redirect_o,
   output logic [`RV_XLEN-1:0] target_o,
   output rv_pkg::rv_ctrl_t    ctrl_o,
   output logic [`RV_XLEN-1:0] result_o,
   output logic [`RV_XLEN-1:0] store_o,
   output logic [`RV_XLEN-1:0] pc_o
);
   logic [`RV_XLEN-1:0] a;
   logic [`RV_XLEN-1:0] b;
   logic [`RV_XLEN-1:0] result;
   logic                take;

   // younger stage wins
   function automatic logic [`RV_XLEN-1:0] forward(input logic [4:0]          rs,
                                                   input logic [`RV_XLEN-1:0] reg_val);
      if (mem_fwd.valid && mem_fwd.we && (mem_fwd.rd == rs) && (rs != 5'd0)) begin
         return mem_fwd.data;
      end
      if (wb_fwd.valid && wb_fwd.we && (wb_fwd.rd == rs) && (rs != 5'd0)) begin
         return wb_fwd.data;
      end
      return reg_val;
   endfunction

   always_comb begin
      a = forward(ctrl_i.rs1, op1_i);
      b = forward(ctrl_i.rs2, op2_i);
      case (ctrl_i.op)
         rv_pkg::OP_ADD:  result = a + b;
         rv_pkg::OP_SUB:  result = a - b;
         rv_pkg::OP_AND:  result = a & b;
         rv_pkg::OP_OR:   result = a | b;
         rv_pkg::OP_XOR:  result = a ^ b;
         rv_pkg::OP_SLT:  result = {{(`RV_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
         rv_pkg::OP_ADDI: result = a + imm_i;
         rv_pkg::OP_ANDI: result = a & imm_i;
         rv_pkg::OP_ORI:  result = a | imm_i;
         rv_pkg::OP_XORI: result = a ^ imm_i;
         rv_pkg::OP_LUI:  result = imm_i;
         // effective address for loads and stores
         rv_pkg::OP_LW:   result = a + imm_i;
         rv_pkg::OP_SW:   result = a + imm_i;
         rv_pkg::OP_JAL:  result = pc_i + 'd4;
         default:         result = '0;
      endcase
      take = ctrl_i.valid &&
             (((ctrl_i.op == rv_pkg::OP_BEQ) && (a == b)) ||
              ((ctrl_i.op == rv_pkg::OP_BNE) && (a != b)) ||
              (ctrl_i.op == rv_pkg::OP_JAL));
   end

   always_ff @(posedge clk) begin
      if (reset || flush_i) begin
         ctrl_o     <= '0;
         redirect_o <= 1'b0;
      end else begin
         ctrl_o     <= ctrl_i;
         redirect_o <= take;
      end
   end

   always_ff @(posedge clk) begin
      result_o <= result;
      store_o  <= b;
      pc_o     <= pc_i;
      target_o <= pc_i + imm_i;
   end

   // redirects come from live instructions and land on word boundaries
   a_redirect_valid : assert property (@(posedge clk) disable iff (reset)
      redirect_o |-> ctrl_o.valid && (target_o[1:0] == 2'b00))
      else $error("redirect without a valid control or to an unaligned target");

endmodule

//--- source/rv_fetch.sv
`timescale 1ns/1ns
`include "rv_config.svh"

module rv_fetch (
   input  logic                               clk,
   input  logic                               reset,
   input  logic                               run_i,
   input  logic                               imem_we_i,
   input  logic [$clog2(`RV_IMEM_WORDS)-1:0]  imem_addr_i,
   input  logic [31:0]                        imem_data_i,
   input  logic                               redirect_i,
   input  logic [`RV_XLEN-1:0]                target_i,
   output logic                               valid_o,
   output logic [`RV_XLEN-1:0]                pc_o,
   output logic [31:0]                        instr_o
);
   localparam int AW = $clog2(`RV_IMEM_WORDS);

   logic [31:0]         imem [`RV_IMEM_WORDS];
   logic [`RV_XLEN-1:0] pc;

   // program load port
   always_ff @(posedge clk) begin
      if (imem_we_i) begin
         imem[imem_addr_i] <= imem_data_i;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc      <= '0;
         valid_o <= 1'b0;
      end else if (redirect_i) begin
         pc      <= target_i;
         valid_o <= 1'b0;
      end else if (run_i) begin
         pc      <= pc + 'd4;
         valid_o <= 1'b1;
      end else begin
         valid_o <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      pc_o    <= pc;
      instr_o <= imem[pc[AW+1:2]];
   end

   // program is only loaded while the core is stopped
   a_no_load_while_running : assert property (@(posedge clk) disable iff (reset)
      run_i |-> !imem_we_i)
      else $error("instruction memory written while running");

endmodule

//--- source/rv_memory.sv
`timescale 1ns/1ns
`include "rv_config.svh"

module rv_memory (
   input  logic                clk,
   input  logic                reset,
   input  rv_pkg::rv_ctrl_t    ctrl_i,
   input  logic [`RV_XLEN-1:0] pc_i,
   input  logic [`RV_XLEN-1:0] result_i,
   input  logic [`RV_XLEN-1:0] store_i,
   rv_wb_if.src                mem_bus,
   rv_wb_if.src                wb_bus,
   output logic [`RV_XLEN-1:0] pc_o
);
   localparam int AW = $clog2(`RV_DMEM_WORDS);

   logic [`RV_XLEN-1:0] dmem [`RV_DMEM_WORDS];
   logic [`RV_XLEN-3:0] word_addr;
   logic [`RV_XLEN-1:0] load_data;

   assign word_addr = result_i[`RV_XLEN-1:2];
   // combinational read, forwarded in the same cycle
   assign load_data = dmem[word_addr[AW-1:0]];

   assign mem_bus.valid = ctrl_i.valid;
   assign mem_bus.we    = ctrl_i.reg_write;
   assign mem_bus.rd    = ctrl_i.rd;
   assign mem_bus.data  = ctrl_i.mem_read ? load_data : result_i;

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
            dmem[i] <= '0;
         end
      end else if (ctrl_i.valid && ctrl_i.mem_write) begin
         dmem[word_addr[AW-1:0]] <= store_i;
      end
   end

   // memory/write-back register
   always_ff @(posedge clk) begin
      if (reset) begin
         wb_bus.valid <= 1'b0;
         wb_bus.we    <= 1'b0;
      end else begin
         wb_bus.valid <= mem_bus.valid;
         wb_bus.we    <= mem_bus.we;
      end
   end

   always_ff @(posedge clk) begin
      wb_bus.rd   <= mem_bus.rd;
      wb_bus.data <= mem_bus.data;
      pc_o        <= pc_i;
   end

   a_dmem_range : assert property (@(posedge clk) disable iff (reset)
      (ctrl_i.valid && (ctrl_i.mem_read || ctrl_i.mem_write)) |->
         (word_addr < `RV_DMEM_WORDS))
      else $error("data address out of range: %h", result_i);

endmodule

//--- source/rv_pkg.sv
package rv_pkg;

   // base opcodes of the supported formats
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;

   // OP_NOP must stay first, a cleared control word is a bubble
   typedef enum logic [4:0] {
      OP_NOP,
      OP_ADD,
      OP_SUB,
      OP_AND,
      OP_OR,
      OP_XOR,
      OP_SLT,
      OP_ADDI,
      OP_ANDI,
      OP_ORI,
      OP_XORI,
      OP_LUI,
      OP_LW,
      OP_SW,
      OP_BEQ,
      OP_BNE,
      OP_JAL
   } rv_op_e;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } rv_r_t;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } rv_i_t;

   typedef struct packed {
      logic [6:0] imm11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm4_0;
      logic [6:0] opcode;
   } rv_s_t;

   // branch and jump immediates share the sign bit and bits 10:5
   typedef struct packed {
      logic       sign;
      logic [5:0] imm10_5;
      logic [3:0] j_imm4_1;
      logic       j_imm11;
      logic [7:0] j_imm19_12;
      logic [3:0] b_imm4_1;
      logic       b_imm11;
      logic [6:0] opcode;
   } rv_bj_t;

   typedef union packed {
      rv_r_t  r;
      rv_i_t  i;
      rv_s_t  s;
      rv_bj_t bj;
   } rv_instr_u;

   typedef struct packed {
      logic       valid;
      rv_op_e     op;
      logic [4:0] rd;
      logic [4:0] rs1;
      logic [4:0] rs2;
      logic       reg_write;
      logic       mem_read;
      logic       mem_write;
   } rv_ctrl_t;

endpackage

//--- source/rv_reg_file.sv
`timescale 1ns/1ns
`include "rv_config.svh"

module rv_reg_file (
   input  logic                clk,
   input  logic                reset,
   input  logic [4:0]          rs1_i,
   input  logic [4:0]          rs2_i,
   output logic [`RV_XLEN-1:0] rd1_o,
   output logic [`RV_XLEN-1:0] rd2_o,
   rv_wb_if.wr                 wb
);
   logic [`RV_XLEN-1:0] regs [`RV_NREGS];
   logic                wr_en;

   assign wr_en = wb.valid && wb.we && (wb.rd != 5'd0);

   // x0 reads zero, a same-cycle write is bypassed
   function automatic logic [`RV_XLEN-1:0] read_port(input logic [4:0] rs);
      if (rs == 5'd0) begin
         return '0;
      end
      if (wr_en && (wb.rd == rs)) begin
         return wb.data;
      end
      return regs[rs];
   endfunction

   always_comb begin
      rd1_o = read_port(rs1_i);
      rd2_o = read_port(rs2_i);
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `RV_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wb.rd] <= wb.data;
      end
   end

endmodule

//--- source/rv_wb_if.sv
`timescale 1ns/1ns
`include "rv_config.svh"

// one stage's register write, seen by forwarding and the register file
interface rv_wb_if;
   logic                valid;
   logic                we;
   logic [4:0]          rd;
   logic [`RV_XLEN-1:0] data;

   // driven by the memory stage
   modport src (output valid, we, rd, data);

   // operand forwarding in execute
   modport fwd (input valid, we, rd, data);

   // register file write port
   modport wr (input valid, we, rd, data);

endinterface

//--- verilog.f
+incdir+source
source/rv_pkg.sv
source/rv_wb_if.sv
source/rv_fetch.sv
source/rv_reg_file.sv
source/rv_decode.sv
source/rv_execute.sv
source/rv_memory.sv
source/rv_core.sv
bench/rv_retire_checker.sv
bench/rv_core_tb.sv
